// ==== kbc_pkg.sv ====
`default_nettype none

package kbc_pkg;

  // ------------------------------
  // Host register map
  // ------------------------------
  // Internal address is {wb_adr_i[2:1], wb_sel_i[1]}
  localparam logic [2:0] kbc_data_addr_c = 3'b000;  // Port 0x60
  localparam logic [2:0] kbc_cmd_addr_c  = 3'b100;  // Port 0x64, status on read

  // Controller commands written to port 0x64
  typedef enum logic [7:0] {
    cmd_read_ctrl  = 8'h20,  // Next data read returns control byte
    cmd_write_ctrl = 8'h60,  // Next data write loads control byte
    cmd_mouse_test = 8'hA9,  // Mouse interface test
    cmd_self_test  = 8'hAA   // Controller self test
  } kbc_cmd_e;

  // What the data port returns before any device byte
  typedef enum logic [1:0] {
    reply_none,
    reply_ctrl,
    reply_self_test,
    reply_mouse_test
  } kbc_reply_e;

  localparam logic [7:0] kbc_ctrl_default_c  = 8'h47;  // Both irqs on, SYS set, xlat bit
  localparam logic [7:0] kbc_self_test_ok_c  = 8'h55;
  localparam logic [7:0] kbc_mouse_test_ok_c = 8'h00;  // No stuck lines

  localparam int kbc_num_dev_c = 2;
  localparam int kbc_kbd_dev_c = 0;  // Keyboard channel
  localparam int kbc_mse_dev_c = 1;  // Mouse channel

endpackage

`default_nettype wire

// ==== ps2_pkg.sv ====
`default_nettype none

package ps2_pkg;

  // ------------------------------
  // PS/2 device frame
  // ------------------------------
  // Start bit, 8 data bits LSB first, odd parity, stop bit
  localparam int ps2_frame_bits_c = 11;

  // Equal samples needed before a new clock level is taken
  localparam int ps2_filter_len_c = 4;

  // Cycles without a falling edge before a partial frame is dropped
  localparam int ps2_timeout_c = 2000;

  // Receiver FSM
  typedef enum logic [1:0] {
    rx_idle,   // Waiting for start bit edge
    rx_shift,  // Collecting the rest of the frame
    rx_check   // Frame complete, check and load
  } ps2_rx_state_e;

endpackage

`default_nettype wire

// ==== ps2_rx_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// One receive channel's buffer as seen by the register block
interface ps2_rx_if;

  logic [7:0] data;  // Buffered byte
  logic       full;  // Byte waiting for the host
  logic       perr;  // One-cycle strobe on a bad frame
  logic       pop;   // One-cycle strobe from host, empties buffer

  // Receiver side
  modport channel (
    output data,
    output full,
    output perr,
    input  pop
  );

  // Register block side
  modport host (
    input  data,
    input  full,
    input  perr,
    output pop
  );

endinterface

`default_nettype wire

// ==== ps2_line_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_line_sync (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  input  logic [1:0] ps2_clk_i,  // Raw device clock, per channel
  input  logic [1:0] ps2_dat_i,  // Raw device data, per channel
  output logic [1:0] fall_o,     // Accepted falling clock edge
  output logic [1:0] bit_o       // Data level at that edge
);

  for (genvar d = 0; d < 2; d++) begin : g_dev

    logic [1:0] clk_sync_q;  // Two-flop synchronizer, [1] is stable
    logic [1:0] dat_sync_q;
    logic       clk_filt_q;  // Accepted clock level
    logic [$clog2(ps2_pkg::ps2_filter_len_c)-1:0] cnt_q;  // Run of differing samples
    logic       fall_q;
    logic       bit_q;

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
        clk_sync_q <= 2'b11;  // Idle bus is high
        dat_sync_q <= 2'b11;
        clk_filt_q <= 1'b1;
        cnt_q      <= '0;
        fall_q     <= 1'b0;
        bit_q      <= 1'b1;
      end else begin
        clk_sync_q <= {clk_sync_q[0], ps2_clk_i[d]};
        dat_sync_q <= {dat_sync_q[0], ps2_dat_i[d]};
        fall_q     <= 1'b0;  // Strobe by default

        // Deglitch the clock
        if (clk_sync_q[1] == clk_filt_q) begin
          cnt_q <= '0;  // Glitch gone, restart count
        end else if (int'(cnt_q) == ps2_pkg::ps2_filter_len_c - 1) begin
          clk_filt_q <= clk_sync_q[1];  // New level accepted
          cnt_q      <= '0;
          fall_q     <= clk_filt_q;     // Was high so this is a fall
          bit_q      <= dat_sync_q[1];  // Data is stable around the fall
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end

    assign fall_o[d] = fall_q;
    assign bit_o[d]  = bit_q;

  end

endmodule

`default_nettype wire

// ==== ps2_rx_channel.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_rx_channel (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic fall_i,  // Filtered falling clock edge
  input  logic bit_i,   // Data level at the edge
  ps2_rx_if.channel rx
);

  ps2_pkg::ps2_rx_state_e state_q;

  logic [ps2_pkg::ps2_frame_bits_c-1:0] shift_q;  // [0] start ... [10] stop
  logic [$clog2(ps2_pkg::ps2_frame_bits_c)-1:0] bit_cnt_q;
  logic [$clog2(ps2_pkg::ps2_timeout_c)-1:0] tmo_q;  // Cycles since last edge
  logic [7:0] data_q;
  logic       full_q;
  logic       perr_q;
  logic       frame_ok;
  logic       load;

  // ------------------------------
  // Frame check
  // ------------------------------
  assign frame_ok = ~shift_q[0]                       // Start bit low
                  & shift_q[ps2_pkg::ps2_frame_bits_c-1]  // Stop bit high
                  & (^shift_q[9:1]);                  // Odd parity over data and parity
  assign load = (state_q == ps2_pkg::rx_check) & frame_ok & ~full_q;  // Overrun drops new frame

  // ------------------------------
  // Receiver FSM
  // ------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state_q   <= ps2_pkg::rx_idle;
      bit_cnt_q <= '0;
      tmo_q     <= '0;
      perr_q    <= 1'b0;
    end else begin
      perr_q <= 1'b0;
      case (state_q)
        ps2_pkg::rx_idle: begin
          tmo_q <= '0;
          if (fall_i) begin
            bit_cnt_q <= 1'b1;  // Start bit taken
            state_q   <= ps2_pkg::rx_shift;
          end
        end
        ps2_pkg::rx_shift: begin
          if (fall_i) begin
            tmo_q <= '0;
            if (int'(bit_cnt_q) == ps2_pkg::ps2_frame_bits_c - 1) begin
              state_q <= ps2_pkg::rx_check;  // Stop bit just shifted in
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end else if (int'(tmo_q) == ps2_pkg::ps2_timeout_c - 1) begin
            state_q <= ps2_pkg::rx_idle;  // Device stalled, abandon frame
          end else begin
            tmo_q <= tmo_q + 1'b1;
          end
        end
        ps2_pkg::rx_check: begin
          perr_q  <= ~frame_ok;  // Bad parity or framing
          state_q <= ps2_pkg::rx_idle;
        end
        default: state_q <= ps2_pkg::rx_idle;
      endcase
    end
  end

  // Buffer flag, host pop has priority
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      full_q <= 1'b0;
    end else if (rx.pop) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end
  end

  // Payload
  always_ff @(posedge wb_clk_i) begin
    if (fall_i && state_q != ps2_pkg::rx_check) begin
      shift_q <= {bit_i, shift_q[ps2_pkg::ps2_frame_bits_c-1:1]};  // LSB arrives first
    end
    if (load) begin
      data_q <= shift_q[8:1];
    end
  end

  assign rx.data = data_q;
  assign rx.full = full_q;
  assign rx.perr = perr_q;

endmodule

`default_nettype wire

// ==== kbc_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module kbc_regs (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [15:0] wb_dat_i,
  input  logic [2:1]  wb_adr_i,
  input  logic [1:0]  wb_sel_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_tgk_o,  // Keyboard irq
  output logic        wb_tgm_o,  // Mouse irq
  ps2_rx_if.host      kbd,
  ps2_rx_if.host      mse
);

  logic        ack_q;
  logic        acc;        // Access accepted this cycle
  logic        wr;
  logic        rd;
  logic [2:0]  addr;
  logic        data_sel;
  logic        cmd_sel;
  logic [7:0]  wr_byte;    // Byte from the selected lane
  logic [7:0]  rd_byte;
  logic [7:0]  status;
  logic        ibf;
  logic [15:0] dat_q;

  logic [7:0]  ctrl_q;     // Control byte
  logic        wr_ctrl_q;  // Next data write goes to ctrl_q
  logic        a2_q;       // Last write was to 0x64
  logic        perr_q;     // Sticky parity error
  kbc_pkg::kbc_reply_e reply_q;

  // ------------------------------
  // Bus decode
  // ------------------------------
  assign acc      = wb_cyc_i & wb_stb_i & ~ack_q;  // No back-to-back ack
  assign wr       = acc & wb_we_i;
  assign rd       = acc & ~wb_we_i;
  assign addr     = {wb_adr_i, wb_sel_i[1]};
  assign data_sel = (addr == kbc_pkg::kbc_data_addr_c);
  assign cmd_sel  = (addr == kbc_pkg::kbc_cmd_addr_c);
  assign wr_byte  = wb_sel_i[0] ? wb_dat_i[7:0] : wb_dat_i[15:8];

  // ------------------------------
  // Status and read mux
  // ------------------------------
  assign ibf    = (reply_q != kbc_pkg::reply_none) | kbd.full | mse.full;
  assign status = {perr_q, 1'b0, mse.full, 1'b1, a2_q, ctrl_q[2], 1'b0, ibf};

  always_comb begin
    rd_byte = status;  // Port 0x64 and unmapped reads
    if (data_sel) begin
      case (reply_q)
        kbc_pkg::reply_ctrl:       rd_byte = ctrl_q;
        kbc_pkg::reply_self_test:  rd_byte = kbc_pkg::kbc_self_test_ok_c;
        kbc_pkg::reply_mouse_test: rd_byte = kbc_pkg::kbc_mouse_test_ok_c;
        default:                   rd_byte = mse.full ? mse.data : kbd.data;  // Mouse first
      endcase
    end
  end

  // Pops only when no reply stands in front of the device bytes
  assign mse.pop = rd & data_sel & (reply_q == kbc_pkg::reply_none) & mse.full;
  assign kbd.pop = rd & data_sel & (reply_q == kbc_pkg::reply_none) & ~mse.full & kbd.full;

  // ------------------------------
  // Ack and read data
  // ------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) ack_q <= 1'b0;
    else          ack_q <= acc;  // One cycle after request
  end

  always_ff @(posedge wb_clk_i) begin
    if (rd) begin
      dat_q <= wb_sel_i[0] ? {8'h00, rd_byte} : {rd_byte, 8'h00};  // Back on the same lane
    end
  end

  // ------------------------------
  // Command and control
  // ------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ctrl_q    <= kbc_pkg::kbc_ctrl_default_c;
      wr_ctrl_q <= 1'b0;
      a2_q      <= 1'b0;
      reply_q   <= kbc_pkg::reply_none;
    end else if (wr && cmd_sel) begin
      a2_q <= 1'b1;
      case (wr_byte)
        kbc_pkg::cmd_read_ctrl: begin
          reply_q   <= kbc_pkg::reply_ctrl;
          wr_ctrl_q <= 1'b0;
        end
        kbc_pkg::cmd_write_ctrl: begin
          reply_q   <= kbc_pkg::reply_none;  // New command drops old reply
          wr_ctrl_q <= 1'b1;
        end
        kbc_pkg::cmd_self_test: begin
          reply_q   <= kbc_pkg::reply_self_test;
          wr_ctrl_q <= 1'b0;
        end
        kbc_pkg::cmd_mouse_test: begin
          reply_q   <= kbc_pkg::reply_mouse_test;
          wr_ctrl_q <= 1'b0;
        end
        default: ;  // Unsupported commands ignored
      endcase
    end else if (wr && data_sel) begin
      a2_q <= 1'b0;
      if (wr_ctrl_q) begin
        ctrl_q    <= wr_byte;
        wr_ctrl_q <= 1'b0;
      end
    end else if (rd && data_sel) begin
      reply_q <= kbc_pkg::reply_none;  // Reply consumed, or already none
    end
  end

  // Sticky PERR, a new error beats the clearing read
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      perr_q <= 1'b0;
    end else if (kbd.perr || mse.perr) begin
      perr_q <= 1'b1;
    end else if (rd && cmd_sel) begin
      perr_q <= 1'b0;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;
  assign wb_tgk_o = kbd.full & ctrl_q[0];
  assign wb_tgm_o = mse.full & ctrl_q[1];

endmodule

`default_nettype wire

// ==== ps2_kbc.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_kbc (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  input  logic [2:1]  wb_adr_i,   // Upper bits decoded outside
  input  logic [1:0]  wb_sel_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  output logic        wb_ack_o,
  output logic        wb_tgk_o,   // Keyboard irq
  output logic        wb_tgm_o,   // Mouse irq
  input  logic [1:0]  ps2_clk_i,  // [0] keyboard, [1] mouse
  input  logic [1:0]  ps2_dat_i
);

  logic [kbc_pkg::kbc_num_dev_c-1:0] fall;  // Filtered clock falls
  logic [kbc_pkg::kbc_num_dev_c-1:0] bits;  // Data at each fall

  ps2_rx_if rx_if [kbc_pkg::kbc_num_dev_c] ();  // One buffer per device

  // ------------------------------
  // Line front end
  // ------------------------------
  ps2_line_sync u_sync (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .ps2_clk_i (ps2_clk_i),
    .ps2_dat_i (ps2_dat_i),
    .fall_o    (fall),
    .bit_o     (bits)
  );

  // Identical receivers
  for (genvar g = 0; g < kbc_pkg::kbc_num_dev_c; g++) begin : g_chan
    ps2_rx_channel u_chan (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .fall_i   (fall[g]),
      .bit_i    (bits[g]),
      .rx       (rx_if[g])
    );
  end

  // ------------------------------
  // Host registers
  // ------------------------------
  kbc_regs u_regs (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_dat_i (wb_dat_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_tgk_o (wb_tgk_o),
    .wb_tgm_o (wb_tgm_o),
    .kbd      (rx_if[kbc_pkg::kbc_kbd_dev_c]),
    .mse      (rx_if[kbc_pkg::kbc_mse_dev_c])
  );

endmodule

`default_nettype wire

// ==== tb_ps2_kbc.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ps2_kbc;

  localparam logic [2:1] data_port_c = 2'b00;  // Port 0x60
  localparam logic [2:1] cmd_port_c  = 2'b10;  // Port 0x64
  localparam int half_bit_c   = 40;            // PS/2 clock half period in cycles
  localparam int frame_cyc_c  = 11 * 2 * half_bit_c;
  localparam int num_frames_c = 11;            // Frames sent over all tests
  localparam int margin_c     = 20000;         // Reset, bus traffic and polling

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic [2:1]  wb_adr_i;
  logic [1:0]  wb_sel_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic        wb_ack_o;
  logic        wb_tgk_o;
  logic        wb_tgm_o;
  logic [1:0]  ps2_clk_i;
  logic [1:0]  ps2_dat_i;

  integer seed;
  int     tests;
  int     failed_tests;
  int     checks;
  int     errors;

  ps2_kbc uut (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_ack_o (wb_ack_o),
    .wb_tgk_o (wb_tgk_o),
    .wb_tgm_o (wb_tgm_o),
    .ps2_clk_i(ps2_clk_i),
    .ps2_dat_i(ps2_dat_i)
  );

  always #5 wb_clk_i = ~wb_clk_i;  // 10 ns period

  // ------------------------------
  // Checks and bookkeeping
  // ------------------------------
  task automatic expect_val(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %0t: %s, got %02h, expected %02h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %0d %s: passed", tests, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: failed with %0d errors", tests, name, errors - errs_before);
    end
  endtask

  function automatic logic [7:0] rand_byte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // ------------------------------
  // Wishbone master, low byte lane
  // ------------------------------
  // Called and left on a falling edge
  task automatic transfer(input logic we, input logic [2:1] adr, input logic [7:0] wdat,
                          output logic [7:0] rdat);
    int waited;
    waited = 0;
    rdat   = 8'h00;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_sel_i = 2'b01;
    wb_dat_i = {8'h00, wdat};
    @(negedge wb_clk_i);
    while (!wb_ack_o && waited < 20) begin  // Hold request until ack
      @(negedge wb_clk_i);
      waited++;
    end
    if (wb_ack_o) begin
      rdat = wb_dat_o[7:0];  // Registered data valid with ack
      if (!we) begin
        expect_val(wb_dat_o[15:8], 8'h00, "unselected read lane");
      end
    end else begin
      $display("Bus error at %0t: no ack within 20 cycles", $time);
      errors++;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge wb_clk_i);
    expect_val({7'd0, wb_ack_o}, 8'h00, "ack held past one cycle");
  endtask

  task automatic write_port(input logic [2:1] adr, input logic [7:0] dat);
    logic [7:0] unused;
    transfer(1'b1, adr, dat, unused);
  endtask

  task automatic read_port(input logic [2:1] adr, output logic [7:0] dat);
    transfer(1'b0, adr, 8'h00, dat);
  endtask

  // Reads status until a bit of mask shows up
  task automatic poll_status(input logic [7:0] mask, output logic [7:0] st);
    int tries;
    tries = 0;
    st    = 8'h00;
    while ((st & mask) == 8'h00 && tries < 1000) begin
      read_port(cmd_port_c, st);
      tries++;
    end
    if ((st & mask) == 8'h00) begin
      $display("Timeout at %0t: status bits %02h never set", $time, mask);
      errors++;
    end
  endtask

  // ------------------------------
  // PS/2 device model
  // ------------------------------
  task automatic send_frame(input int dev, input logic [7:0] b, input logic corrupt);
    logic [10:0] frame;
    frame = {1'b1, (~^b) ^ corrupt, b, 1'b0};  // Stop, odd parity, data, start
    for (int i = 0; i < 11; i++) begin
      ps2_dat_i[dev] = frame[i];  // Data changes while clock is high
      repeat (half_bit_c) @(negedge wb_clk_i);
      ps2_clk_i[dev] = 1'b0;
      repeat (half_bit_c) @(negedge wb_clk_i);
      ps2_clk_i[dev] = 1'b1;
    end
    ps2_dat_i[dev] = 1'b1;
    repeat (half_bit_c) @(negedge wb_clk_i);  // Idle gap
  endtask

  // Ends a run that stalls
  initial begin
    repeat (num_frames_c * frame_cyc_c + margin_c) @(posedge wb_clk_i);
    $display("Watchdog expired at %0t, run stopped", $time);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    logic [7:0] rd;
    logic [7:0] st;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] ctrl;
    int         e0;
    seed = 16000;
    tests = 0;
    failed_tests = 0;
    checks = 0;
    errors = 0;
    wb_clk_i  = 1'b0;
    wb_rst_i  = 1'b1;
    wb_dat_i  = 16'h0000;
    wb_adr_i  = 2'b00;
    wb_sel_i  = 2'b00;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    ps2_clk_i = 2'b11;  // Idle lines
    ps2_dat_i = 2'b11;
    repeat (10) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    @(negedge wb_clk_i);

    // Reset values
    e0 = errors;
    expect_val({7'd0, wb_ack_o}, 8'h00, "ack after reset");
    expect_val({6'd0, wb_tgm_o, wb_tgk_o}, 8'h00, "irqs after reset");
    read_port(cmd_port_c, st);
    expect_val(st, 8'h14, "status after reset");  // INH and SYS
    write_port(cmd_port_c, 8'h20);
    read_port(data_port_c, rd);
    expect_val(rd, 8'h47, "control byte after reset");
    finish_test("reset defaults", e0);

    // Control byte write, A2 and SYS, both SYS levels
    e0 = errors;
    ctrl = rand_byte();
    for (int k = 0; k < 2; k++) begin
      write_port(cmd_port_c, 8'h60);
      read_port(cmd_port_c, st);
      expect_val(st & 8'h08, 8'h08, "A2 after command write");
      write_port(data_port_c, ctrl);
      read_port(cmd_port_c, st);
      expect_val(st & 8'h08, 8'h00, "A2 after data write");
      expect_val(st & 8'h04, ctrl & 8'h04, "SYS follows control bit 2");
      write_port(cmd_port_c, 8'h20);
      read_port(data_port_c, rd);
      expect_val(rd, ctrl, "control byte read back");
      ctrl = ctrl ^ 8'h04;
    end
    ctrl = ctrl ^ 8'h04;  // Value now held by the DUT
    finish_test("control byte and A2", e0);

    // Controller replies
    e0 = errors;
    write_port(cmd_port_c, 8'hAA);
    read_port(cmd_port_c, st);
    expect_val(st & 8'h01, 8'h01, "IBF with self-test reply");
    read_port(data_port_c, rd);
    expect_val(rd, 8'h55, "self-test reply");
    read_port(cmd_port_c, st);
    expect_val(st & 8'h01, 8'h00, "IBF after reply read");
    write_port(cmd_port_c, 8'hA9);
    read_port(data_port_c, rd);
    expect_val(rd, 8'h00, "mouse test reply");
    write_port(cmd_port_c, 8'hAA);
    write_port(cmd_port_c, 8'h20);  // Replaces 0x55
    read_port(data_port_c, rd);
    expect_val(rd, ctrl, "second command replaces reply");
    finish_test("controller replies", e0);

    // Reception with both irqs enabled
    e0 = errors;
    write_port(cmd_port_c, 8'h60);
    write_port(data_port_c, 8'h03);
    b0 = rand_byte();
    send_frame(0, b0, 1'b0);
    poll_status(8'h01, st);
    expect_val({7'd0, wb_tgk_o}, 8'h01, "keyboard irq");
    read_port(data_port_c, rd);
    expect_val(rd, b0, "keyboard byte");
    expect_val({7'd0, wb_tgk_o}, 8'h00, "keyboard irq after read");
    b1 = rand_byte();
    send_frame(1, b1, 1'b0);
    poll_status(8'h20, st);
    expect_val(st & 8'h21, 8'h21, "MOBF and IBF with mouse byte");
    expect_val({7'd0, wb_tgm_o}, 8'h01, "mouse irq");
    read_port(data_port_c, rd);
    expect_val(rd, b1, "mouse byte");
    b0 = rand_byte();
    send_frame(0, b0, 1'b0);
    poll_status(8'h01, st);
    b1 = rand_byte();
    send_frame(1, b1, 1'b0);
    poll_status(8'h20, st);
    read_port(data_port_c, rd);
    expect_val(rd, b1, "mouse byte read first");
    read_port(data_port_c, rd);
    expect_val(rd, b0, "keyboard byte read second");
    read_port(cmd_port_c, st);
    expect_val(st & 8'h21, 8'h00, "buffers empty after reads");
    finish_test("device reception", e0);

    // Overrun keeps old byte, bad parity sets PERR
    e0 = errors;
    b0 = rand_byte();
    send_frame(0, b0, 1'b0);
    poll_status(8'h01, st);
    send_frame(0, ~b0, 1'b0);  // Arrives while full
    read_port(data_port_c, rd);
    expect_val(rd, b0, "overrun keeps first byte");
    read_port(cmd_port_c, st);
    expect_val(st & 8'h01, 8'h00, "overrun byte not loaded");
    b1 = rand_byte();
    send_frame(0, b1, 1'b1);
    poll_status(8'h80, st);
    expect_val(st & 8'h81, 8'h80, "PERR set, no byte loaded");
    read_port(cmd_port_c, st);
    expect_val(st & 8'h81, 8'h00, "PERR cleared by status read");
    finish_test("overrun and parity", e0);

    // Irqs masked, data still flows
    e0 = errors;
    write_port(cmd_port_c, 8'h60);
    write_port(data_port_c, 8'h00);
    for (int k = 0; k < 2; k++) begin
      b0 = rand_byte();
      send_frame(0, b0, 1'b0);
      poll_status(8'h01, st);
      b1 = rand_byte();
      send_frame(1, b1, 1'b0);
      poll_status(8'h20, st);
      expect_val({6'd0, wb_tgm_o, wb_tgk_o}, 8'h00, "irqs masked");
      read_port(data_port_c, rd);
      expect_val(rd, b1, "masked mouse byte");
      read_port(data_port_c, rd);
      expect_val(rd, b0, "masked keyboard byte");
    end
    finish_test("interrupt masking", e0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
kbc_pkg.sv
ps2_pkg.sv
ps2_rx_if.sv
ps2_line_sync.sv
ps2_rx_channel.sv
kbc_regs.sv
ps2_kbc.sv
tb_ps2_kbc.sv

// ==== Makefile ====
# Verilator simulation of the PS/2 controller

TOP = tb_ps2_kbc

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only -Wall -f all.f --top-module ps2_kbc

clean:
	rm -rf obj_dir sim.log
